// File: loopPkg.sv
package loopPkg;

  // Datapath widths.
  localparam int addrW = 18;  // Program address.
  localparam int cntW = 16;   // Loop count.

  // Stack geometry, shared by all three loop stacks.
  localparam int stackDepth = 4;
  localparam int idxW = $clog2(stackDepth);
  localparam int ptrW = idxW + 1;  // MSB set means empty.

  // Pointer values the flags are decoded from.
  localparam logic [ptrW-1:0] ptrEmpty = '1;
  localparam logic [ptrW-1:0] ptrOne = '0;
  localparam logic [ptrW-1:0] ptrFull = ptrW'(stackDepth - 1);

  // Termination condition of a DO UNTIL, tested at the end address.
  typedef enum logic [3:0] {
    condCE      = 4'h0,  // Counter expired.
    condEQ      = 4'h1,  // ALU result zero.
    condNE      = 4'h2,
    condLT      = 4'h3,  // ALU result negative.
    condGE      = 4'h4,
    condForever = 4'hf   // Never terminates.
  } termCondT;

  // One entry of the loop-end stack.
  typedef struct packed {
    logic [addrW-1:0] endAddr;
    termCondT         cond;
  } loopEntryT;

  localparam int entryW = $bits(loopEntryT);  // 22 bits.

endpackage

// File: stackIf.sv
interface stackIf #(
  parameter int W = 8
) ();

  // Requests and write data from the user side.
  logic         push;
  logic         pop;
  logic [W-1:0] din;

  // Top of stack and status from the stack side.
  logic [W-1:0] top;
  logic         full;
  logic         empty;
  logic         has1;   // Exactly one entry left.

  modport owner (
    input  push,
    input  pop,
    input  din,
    output top,
    output full,
    output empty,
    output has1
  );

  modport user (
    output push,
    output pop,
    output din,
    input  top,
    input  full,
    input  empty,
    input  has1
  );

endinterface

// File: lifoRam.sv
module lifoRam import loopPkg::*; #(
  parameter int W = entryW
) (
  input  logic            LPSCLK,
  input  logic            we,
  input  logic [idxW-1:0] wa,
  input  logic [W-1:0]    wdata,
  input  logic [idxW-1:0] ra,
  output logic [W-1:0]    rdata
);

  logic [W-1:0] mem [stackDepth];

  always_ff @(posedge LPSCLK) begin
    if (we) begin
      mem[wa] <= wdata;
    end
  end

  // Top of stack is visible without waiting for a clock.
  assign rdata = mem[ra];

endmodule

// File: lifoStack.sv
module lifoStack import loopPkg::*; #(
  parameter int W = entryW
) (
  input  logic   LPSCLK,
  input  logic   T_RST,
  stackIf.owner  s,
  output logic   overflow
);

  logic [ptrW-1:0] ptr;
  logic [ptrW-1:0] ptrInc;
  logic [ptrW-1:0] ptrDec;
  logic            pushOk;
  logic            popOk;
  logic [idxW-1:0] wrIdx;

  // A pop needs something to pop. A push needs room, unless a pop
  // in the same cycle frees the top slot.
  assign popOk = s.pop && !s.empty;
  assign pushOk = s.push && (!s.full || popOk);

  assign ptrInc = ptr + 1'b1;
  assign ptrDec = ptr - 1'b1;

  always_ff @(posedge LPSCLK or posedge T_RST) begin
    if (T_RST) begin
      ptr <= ptrEmpty;
    end else if (pushOk && !popOk) begin
      ptr <= ptrInc;
    end else if (popOk && !pushOk) begin
      ptr <= ptrDec;
    end
  end

  // Sticky until reset.
  always_ff @(posedge LPSCLK or posedge T_RST) begin
    if (T_RST) begin
      overflow <= 1'b0;
    end else if (s.push && !pushOk) begin
      overflow <= 1'b1;
    end
  end

  assign s.empty = ptr[ptrW-1];
  assign s.full = (ptr == ptrFull);
  assign s.has1 = (ptr == ptrOne);

  // Push and pop together overwrite the current top in place.
  assign wrIdx = popOk ? ptr[idxW-1:0] : ptrInc[idxW-1:0];

  lifoRam #(
    .W(W)
  ) i_ram (
    .LPSCLK(LPSCLK),
    .we    (pushOk),
    .wa    (wrIdx),
    .wdata (s.din),
    .ra    (ptr[idxW-1:0]),
    .rdata (s.top)
  );

endmodule

// File: loopCounter.sv
module loopCounter import loopPkg::*; (
  input  logic            LPSCLK,
  input  logic            T_RST,
  input  logic            cntrLoad,
  input  logic [cntW-1:0] cntrValue,
  input  logic            startLoop,
  input  logic            iterate,
  input  logic            exitLoop,
  output logic [cntW-1:0] activeCount,
  output logic            countExpired
);

  logic [cntW-1:0] pendingCount;

  stackIf #(.W(cntW)) cntIf ();

  // Count for the next DO UNTIL, written ahead of it.
  always_ff @(posedge LPSCLK or posedge T_RST) begin
    if (T_RST) begin
      pendingCount <= '0;
    end else if (cntrLoad) begin
      pendingCount <= cntrValue;
    end
  end

  // A new loop and an exiting loop in the same cycle leave the outer
  // count on the stack untouched and just swap the active count.
  always_ff @(posedge LPSCLK or posedge T_RST) begin
    if (T_RST) begin
      activeCount <= '0;
    end else if (startLoop) begin
      activeCount <= pendingCount;
    end else if (exitLoop) begin
      activeCount <= cntIf.top;  // Outer loop's count.
    end else if (iterate && !countExpired) begin
      activeCount <= activeCount - 1'b1;
    end
  end

  assign cntIf.push = startLoop && !exitLoop;
  assign cntIf.pop = exitLoop && !startLoop;
  assign cntIf.din = activeCount;

  // A count of 0 behaves like 1, so the body runs once.
  assign countExpired = (activeCount <= cntW'(1));

  lifoStack #(
    .W(cntW)
  ) i_cntStack (
    .LPSCLK  (LPSCLK),
    .T_RST   (T_RST),
    .s       (cntIf),
    .overflow()
  );

endmodule

// File: loopSequencer.sv
module loopSequencer import loopPkg::*; (
  input  logic             LPSCLK,
  input  logic             T_RST,
  // DO UNTIL command.
  input  logic             doUntil,
  input  logic [addrW-1:0] loopStart,
  input  logic [addrW-1:0] loopEnd,
  input  termCondT         termCond,
  // Fetch stream and flags.
  input  logic             fetchValid,
  input  logic [addrW-1:0] fetchAddr,
  input  logic             aluZero,
  input  logic             aluNeg,
  input  logic             countExpired,
  // Loop-end and loop-start stacks.
  stackIf.user             loopIf,
  stackIf.user             startIf,
  // Counter strobes.
  output logic             startLoop,
  output logic             iterate,
  output logic             exitLoop,
  // To the fetch unit.
  output logic             loopJump,
  output logic [addrW-1:0] loopTarget,
  output logic             loopActive
);

  loopEntryT topEntry;
  loopEntryT newEntry;
  logic      endMatch;
  logic      terminate;

  assign topEntry = loopIf.top;

  assign newEntry.endAddr = loopEnd;
  assign newEntry.cond = termCond;

  // Only the innermost loop is checked.
  assign endMatch = fetchValid && !loopIf.empty && (fetchAddr == topEntry.endAddr);

  // DO UNTIL semantics: the loop ends once its condition holds.
  always_comb begin
    case (topEntry.cond)
      condCE:      terminate = countExpired;
      condEQ:      terminate = aluZero;
      condNE:      terminate = !aluZero;
      condLT:      terminate = aluNeg;
      condGE:      terminate = !aluNeg;
      condForever: terminate = 1'b0;
      default:     terminate = 1'b1;  // Unknown code ends the loop.
    endcase
  end

  assign loopJump = endMatch && !terminate;
  assign loopTarget = startIf.top;

  assign iterate = loopJump && (topEntry.cond == condCE);
  assign exitLoop = endMatch && terminate;

  // The stacks refuse a push when full on their own, the counter
  // strobe has to follow the same rule.
  assign startLoop = doUntil && (!loopIf.full || exitLoop);

  assign loopIf.push = doUntil;
  assign loopIf.din = newEntry;
  assign loopIf.pop = exitLoop;

  assign startIf.push = doUntil;
  assign startIf.din = loopStart;
  assign startIf.pop = exitLoop;

  // Falls when the last remaining loop exits.
  always_ff @(posedge LPSCLK or posedge T_RST) begin
    if (T_RST) begin
      loopActive <= 1'b0;
    end else if (startLoop) begin
      loopActive <= 1'b1;
    end else if (exitLoop && loopIf.has1) begin
      loopActive <= 1'b0;
    end
  end

endmodule

// File: loopUnit.sv
module loopUnit import loopPkg::*; (
  input  logic             LPSCLK,
  input  logic             T_RST,
  input  logic             doUntil,
  input  logic [addrW-1:0] loopStart,
  input  logic [addrW-1:0] loopEnd,
  input  termCondT         termCond,
  input  logic             cntrLoad,
  input  logic [cntW-1:0]  cntrValue,
  input  logic             fetchValid,
  input  logic [addrW-1:0] fetchAddr,
  input  logic             aluZero,
  input  logic             aluNeg,
  output logic             loopJump,
  output logic [addrW-1:0] loopTarget,
  output logic             loopActive,
  output logic             loopFull,
  output logic             loopOverflow,
  output logic [cntW-1:0]  activeCount
);

  logic startLoop;
  logic iterate;
  logic exitLoop;
  logic countExpired;

  stackIf #(.W(entryW)) loopIf ();
  stackIf #(.W(addrW))  startIf ();

  loopSequencer i_loopSequencer (
    .LPSCLK      (LPSCLK),
    .T_RST       (T_RST),
    .doUntil     (doUntil),
    .loopStart   (loopStart),
    .loopEnd     (loopEnd),
    .termCond    (termCond),
    .fetchValid  (fetchValid),
    .fetchAddr   (fetchAddr),
    .aluZero     (aluZero),
    .aluNeg      (aluNeg),
    .countExpired(countExpired),
    .loopIf      (loopIf),
    .startIf     (startIf),
    .startLoop   (startLoop),
    .iterate     (iterate),
    .exitLoop    (exitLoop),
    .loopJump    (loopJump),
    .loopTarget  (loopTarget),
    .loopActive  (loopActive)
  );

  loopCounter i_loopCounter (
    .LPSCLK      (LPSCLK),
    .T_RST       (T_RST),
    .cntrLoad    (cntrLoad),
    .cntrValue   (cntrValue),
    .startLoop   (startLoop),
    .iterate     (iterate),
    .exitLoop    (exitLoop),
    .activeCount (activeCount),
    .countExpired(countExpired)
  );

  lifoStack #(.W(entryW)) i_loopStack (
    .LPSCLK  (LPSCLK),
    .T_RST   (T_RST),
    .s       (loopIf),
    .overflow(loopOverflow)
  );

  // Moves in step with the loop stack.
  lifoStack #(.W(addrW)) i_startStack (
    .LPSCLK  (LPSCLK),
    .T_RST   (T_RST),
    .s       (startIf),
    .overflow()
  );

  assign loopFull = loopIf.full;

endmodule

// File: loopUnitAssertions.sv
module loopUnitAssertions (
  input logic LPSCLK,
  input logic T_RST,
  input logic fetchValid,
  input logic loopJump,
  input logic loopFull,
  input logic loopEmpty,
  input logic loopOverflow
);
  timeunit 1ns;
  timeprecision 100ps;

  // A jump back only happens on a fetch.
  jumpNeedsFetch: assert property (
    @(posedge LPSCLK) disable iff (T_RST) loopJump |-> fetchValid
  ) else $error("loopJump is high without fetchValid");

  fullNotEmpty: assert property (
    @(posedge LPSCLK) disable iff (T_RST) !(loopFull && loopEmpty)
  ) else $error("loop stack is full and empty at once");

  // Sticky flag.
  overflowHeld: assert property (
    @(posedge LPSCLK) disable iff (T_RST) !$fell(loopOverflow)
  ) else $error("loopOverflow fell outside reset");

endmodule

bind loopUnit loopUnitAssertions i_loopUnitAssertions (
  .LPSCLK      (LPSCLK),
  .T_RST       (T_RST),
  .fetchValid  (fetchValid),
  .loopJump    (loopJump),
  .loopFull    (loopFull),
  .loopEmpty   (loopIf.empty),
  .loopOverflow(loopOverflow)
);

// File: tbLoopUnit.sv
module tbLoopUnit import loopPkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int resetCycles = 5;
  // A DO UNTIL takes 2 cycles and a fetch 1, summed over the tests below.
  localparam int testCycles = 3 + 8 + 10 + 4 * 13 + 15 + 12;
  localparam int cycleLimit = 9 * (resetCycles + 1) + testCycles + 40;

  logic             LPSCLK;
  logic             T_RST;
  logic             doUntil;
  logic [addrW-1:0] loopStart;
  logic [addrW-1:0] loopEnd;
  termCondT         termCond;
  logic             cntrLoad;
  logic [cntW-1:0]  cntrValue;
  logic             fetchValid;
  logic [addrW-1:0] fetchAddr;
  logic             aluZero;
  logic             aluNeg;
  logic             loopJump;
  logic [addrW-1:0] loopTarget;
  logic             loopActive;
  logic             loopFull;
  logic             loopOverflow;
  logic [cntW-1:0]  activeCount;

  // Reference model, the back of each queue is the innermost loop.
  loopEntryT        entryQ[$];
  logic [addrW-1:0] startQ[$];
  logic [cntW-1:0]  countQ[$];
  logic [cntW-1:0]  modelCount;
  logic [cntW-1:0]  modelPending;
  logic             modelOverflow;

  integer seed = 32'h8bf7_649c;
  int     addrErrors = 0;
  int     countErrors = 0;
  int     bitErrors = 0;
  int     cycles = 0;

  loopUnit i_loopUnit (.*);

  initial LPSCLK = 1'b0;
  always #4 LPSCLK = ~LPSCLK;

  always @(posedge LPSCLK) begin
    cycles++;
    if (cycles > cycleLimit) begin
      $display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic checkAddr(input logic [addrW-1:0] got, input logic [addrW-1:0] exp,
                           input string what);
    if (got !== exp) begin
      addrErrors++;
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkCount(input logic [cntW-1:0] got, input logic [cntW-1:0] exp,
                            input string what);
    if (got !== exp) begin
      countErrors++;
      $display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic checkBit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      bitErrors++;
      $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // DO UNTIL rule, the loop ends once its condition is true.
  function automatic logic loopEnds(input termCondT cond, input logic zero, input logic neg);
    case (cond)
      condCE:  return modelCount <= cntW'(1);
      condEQ:  return zero;
      condNE:  return !zero;
      condLT:  return neg;
      condGE:  return !neg;
      default: return 1'b0;
    endcase
  endfunction

  task automatic applyReset();
    T_RST = 1'b1;
    doUntil = 1'b0;
    loopStart = '0;
    loopEnd = '0;
    termCond = condCE;
    cntrLoad = 1'b0;
    cntrValue = '0;
    fetchValid = 1'b0;
    fetchAddr = '0;
    aluZero = 1'b0;
    aluNeg = 1'b0;
    repeat (resetCycles) @(posedge LPSCLK);
    #1;
    T_RST = 1'b0;
    entryQ.delete();
    startQ.delete();
    countQ.delete();
    modelCount = '0;
    modelPending = '0;
    modelOverflow = 1'b0;
  endtask

  task automatic checkState();
    checkBit(loopActive, entryQ.size() > 0, "loopActive");
    checkBit(loopFull, entryQ.size() == stackDepth, "loopFull");
    checkBit(loopOverflow, modelOverflow, "loopOverflow");
    checkCount(activeCount, modelCount, "activeCount");
    if (entryQ.size() > 0) begin
      checkAddr(loopTarget, startQ[$], "loopTarget");
    end
  endtask

  task automatic doLoop(input logic [addrW-1:0] startA, input logic [addrW-1:0] endA,
                        input termCondT cond, input logic [cntW-1:0] count);
    loopEntryT entry;
    cntrLoad = 1'b1;
    cntrValue = count;
    @(posedge LPSCLK);
    #1;
    cntrLoad = 1'b0;
    modelPending = count;
    doUntil = 1'b1;
    loopStart = startA;
    loopEnd = endA;
    termCond = cond;
    @(posedge LPSCLK);
    #1;
    doUntil = 1'b0;
    entry.endAddr = endA;
    entry.cond = cond;
    if (entryQ.size() < stackDepth) begin
      entryQ.push_back(entry);
      startQ.push_back(startA);
      countQ.push_back(modelCount);
      modelCount = modelPending;
    end else begin
      modelOverflow = 1'b1;  // Dropped.
    end
    checkState();
  endtask

  task automatic fetch(input logic [addrW-1:0] addr, input logic zero, input logic neg);
    loopEntryT topEntry;
    logic      match;
    logic      term;
    logic      expJump;
    topEntry = '0;
    match = 1'b0;
    term = 1'b0;
    fetchValid = 1'b1;
    fetchAddr = addr;
    aluZero = zero;
    aluNeg = neg;
    if (entryQ.size() > 0) begin
      topEntry = entryQ[$];
      match = (addr == topEntry.endAddr);
      term = loopEnds(topEntry.cond, zero, neg);
    end
    expJump = match && !term;
    #2;
    checkBit(loopJump, expJump, "loopJump");
    if (expJump) begin
      checkAddr(loopTarget, startQ[$], "loopTarget on jump");
    end
    @(posedge LPSCLK);
    #1;
    fetchValid = 1'b0;
    if (expJump && topEntry.cond == condCE) begin
      modelCount = modelCount - cntW'(1);
    end else if (match && term) begin
      void'(entryQ.pop_back());
      void'(startQ.pop_back());
      modelCount = countQ.pop_back();  // Outer count comes back.
    end
    checkState();
  endtask

  task automatic testReset();
    logic [31:0] rnd;
    applyReset();
    checkState();
    checkBit(loopJump, 1'b0, "loopJump after reset");
    repeat (3) begin
      rnd = $random(seed);
      fetch(rnd[addrW-1:0], rnd[20], rnd[21]);
    end
  endtask

  task automatic testCountLoop();
    applyReset();
    doLoop(18'h00100, 18'h00140, condCE, 16'd5);
    fetch(18'h00120, 1'b0, 1'b0);
    repeat (5) fetch(18'h00140, 1'b0, 1'b0);
    checkBit(loopActive, 1'b0, "loopActive after count loop");
    checkCount(activeCount, 16'd0, "activeCount after count loop");
  endtask

  task automatic testNested();
    applyReset();
    doLoop(18'h01000, 18'h01080, condCE, 16'd3);
    doLoop(18'h01010, 18'h01040, condCE, 16'd2);
    fetch(18'h01080, 1'b0, 1'b0);  // Outer end is ignored while inner runs.
    repeat (2) fetch(18'h01040, 1'b0, 1'b0);
    checkCount(activeCount, 16'd3, "restored outer count");
    checkAddr(loopTarget, 18'h01000, "restored outer start");
    repeat (3) fetch(18'h01080, 1'b0, 1'b0);
    checkBit(loopActive, 1'b0, "loopActive after nested loops");
  endtask

  task automatic testAluLoops();
    termCondT    conds[4];
    logic [31:0] rnd;
    int          n;
    conds = '{condEQ, condNE, condLT, condGE};
    foreach (conds[i]) begin
      applyReset();
      doLoop(18'h02000, 18'h02020, conds[i], 16'd1);
      n = 0;
      while (entryQ.size() > 0 && n < 10) begin
        rnd = $random(seed);
        fetch(18'h02020, rnd[0], rnd[1]);
        n++;
      end
      // Flags that end the loop, in case the random ones never did.
      if (entryQ.size() > 0) begin
        fetch(18'h02020, conds[i] == condEQ, conds[i] == condLT);
      end
      checkBit(loopActive, 1'b0, "loopActive after ALU loop");
    end
  endtask

  task automatic testOverflow();
    applyReset();
    doLoop(18'h03000, 18'h03010, condCE, 16'd1);
    doLoop(18'h03100, 18'h03110, condCE, 16'd1);
    doLoop(18'h03200, 18'h03210, condCE, 16'd1);
    doLoop(18'h03300, 18'h03310, condCE, 16'd1);
    checkBit(loopFull, 1'b1, "loopFull at four loops");
    doLoop(18'h03400, 18'h03410, condCE, 16'd7);
    checkBit(loopOverflow, 1'b1, "loopOverflow after fifth loop");
    checkAddr(loopTarget, 18'h03300, "top start after overflow");
    fetch(18'h03410, 1'b0, 1'b0);
    fetch(18'h03310, 1'b0, 1'b0);
    fetch(18'h03210, 1'b0, 1'b0);
    fetch(18'h03110, 1'b0, 1'b0);
    fetch(18'h03010, 1'b0, 1'b0);
    checkBit(loopOverflow, 1'b1, "loopOverflow held");
  endtask

  task automatic testForever();
    logic [31:0] rnd;
    applyReset();
    doLoop(18'h04000, 18'h04040, condForever, 16'd0);
    repeat (6) begin
      rnd = $random(seed);
      fetch(18'h04040, rnd[0], rnd[1]);
    end
    repeat (4) begin
      rnd = $random(seed);
      fetch(rnd[addrW-1:0], rnd[20], rnd[21]);
    end
    checkBit(loopActive, 1'b1, "loopActive in forever loop");
  endtask

  initial begin
    testReset();
    testCountLoop();
    testNested();
    testAluLoops();
    testOverflow();
    testForever();
    $display("Checks done: %0d address errors, %0d count errors, %0d flag errors",
             addrErrors, countErrors, bitErrors);
    if (addrErrors + countErrors + bitErrors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: files.f
loopPkg.sv
stackIf.sv
lifoRam.sv
lifoStack.sv
loopCounter.sv
loopSequencer.sv
loopUnit.sv
loopUnitAssertions.sv
tbLoopUnit.sv

// File: run.sh
#!/bin/sh
# Build and run the loop unit testbench, the result is read from its output.
verilator --binary --timing --assert -f files.f --top-module tbLoopUnit -o simLoopUnit &&
  ./obj_dir/simLoopUnit | tee /dev/stderr | grep -qF '** PASS **' &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
